// ==== design/alu6502Pkg.sv ====
/*
 * 6502 datapath slice shared definitions
 * word width, status bit positions, BCD corrections,
 * opcodes and the command, control and response words
 */
package alu6502Pkg;

    // 6502 word
    localparam int dataWidth = 8;

    // status byte layout NV1BDIZC, B and I read as zero here
    localparam int statusC = 0;
    localparam int statusZ = 1;
    localparam int statusD = 3;
    localparam int statusOne = 5;
    localparam int statusV = 6;
    localparam int statusN = 7;
    localparam logic [dataWidth-1:0] statusReset = 8'b0010_0000;

    // nibble corrections for decimal mode
    localparam logic [dataWidth-1:0] bcdLowAdjust = 8'h06;
    localparam logic [dataWidth-1:0] bcdHighAdjust = 8'h60;

    typedef enum logic [3:0] {
        opAdc = 4'd0,
        opSbc = 4'd1,
        opAnd = 4'd2,
        opEor = 4'd3,
        opOra = 4'd4,
        opLsr = 4'd5,
        opLda = 4'd6,
        opLdx = 4'd7,
        opLdy = 4'd8,
        opTax = 4'd9,
        opTay = 4'd10,
        opTxa = 4'd11,
        opTya = 4'd12,
        opFlg = 4'd13
    } aluOp_e;

    // destination register, regP marks the flag op
    typedef enum logic [1:0] {regA, regX, regY, regP} regSel_e;

    // second ALU input source
    typedef enum logic [1:0] {srcArg, srcA, srcX, srcY} srcSel_e;

    typedef enum logic [2:0] {fnAdd, fnAnd, fnEor, fnOr, fnShift, fnPass} aluFunc_e;

    typedef struct packed {
        logic [2:0] reserved;
        logic setC;
        logic clrC;
        logic setD;
        logic clrD;
        logic clrV;
    } flagCtl_t;

    // argument byte, or flag controls for opFlg
    typedef union packed {
        logic [dataWidth-1:0] operand;
        flagCtl_t flags;
    } aluArg_u;

    typedef struct packed {
        aluOp_e op;
        aluArg_u arg;
    } aluCmd_t;

    typedef struct packed {
        logic [dataWidth-1:0] operand;
        srcSel_e src;
        aluFunc_e func;
        logic invert;
        logic useCarry;
        regSel_e dest;
        logic updNZ;
        logic updC;
        logic updV;
        flagCtl_t flagCtl;
    } aluCtl_t;

    typedef struct packed {
        regSel_e dest;
        logic [dataWidth-1:0] value;
        logic [dataWidth-1:0] status;
    } aluRsp_t;

endpackage

// ==== design/decimalAdjust.sv ====
/*
 * BCD correction of a binary add or subtract result
 * nibble fix-ups chosen from the binary carries,
 * plus the decimal carry out
 */
`timescale 1ns/10ps

module decimalAdjust (
    input  logic [alu6502Pkg::dataWidth-1:0] binSum,
    input  logic                             halfCarry,
    input  logic                             binCarry,
    input  logic                             subtract,
    output logic [alu6502Pkg::dataWidth-1:0] bcdSum,
    output logic                             bcdCarry
);
    import alu6502Pkg::*;

    logic [dataWidth-1:0] lowAdj;
    logic [dataWidth-1:0] highAdj;
    logic overRange;

    // binary sum past the largest two-digit BCD value
    assign overRange = binSum > 8'h99;

    always_comb begin
        lowAdj = '0;
        highAdj = '0;
        if (subtract) begin
            // a borrow out of a nibble shows as a clear carry
            if (!halfCarry) begin
                lowAdj = bcdLowAdjust;
            end
            if (!binCarry) begin
                highAdj = bcdHighAdjust;
            end
            bcdSum = binSum - lowAdj - highAdj;
            bcdCarry = binCarry;
        end else begin
            if (binSum[3:0] > 4'd9 || halfCarry) begin
                lowAdj = bcdLowAdjust;
            end
            if (binCarry || overRange) begin
                highAdj = bcdHighAdjust;
            end
            bcdSum = binSum + lowAdj + highAdj;
            bcdCarry = binCarry || overRange;
        end
    end

endmodule

// ==== design/aluDecode.sv ====
/*
 * first pipeline stage
 * holds one command and turns its opcode into control fields
 * for the execute stage
 */
`timescale 1ns/10ps

module aluDecode (
    input  logic                 rstAll,
    input  logic                 rstN,
    input  logic                 cmdValid,
    output logic                 cmdReady,
    input  alu6502Pkg::aluCmd_t  cmd,
    output logic                 ctlValid,
    output alu6502Pkg::aluCtl_t  ctl,
    input  logic                 ctlReady
);
    import alu6502Pkg::*;

    aluCtl_t nextCtl;

    // slot is free, or its item leaves this edge
    assign cmdReady = !ctlValid || ctlReady;

    always_comb begin
        // loads of the argument are the default
        nextCtl = '{operand: cmd.arg.operand, src: srcArg, func: fnPass,
                    invert: 1'b0, useCarry: 1'b0, dest: regA,
                    updNZ: 1'b1, updC: 1'b0, updV: 1'b0, flagCtl: '0};
        case (cmd.op)
            opAdc: begin
                nextCtl.func = fnAdd;
                nextCtl.useCarry = 1'b1;
                nextCtl.updC = 1'b1;
                nextCtl.updV = 1'b1;
            end
            opSbc: begin
                // A + ~arg + C
                nextCtl.func = fnAdd;
                nextCtl.invert = 1'b1;
                nextCtl.useCarry = 1'b1;
                nextCtl.updC = 1'b1;
                nextCtl.updV = 1'b1;
            end
            opAnd: nextCtl.func = fnAnd;
            opEor: nextCtl.func = fnEor;
            opOra: nextCtl.func = fnOr;
            opLsr: begin
                // accumulator shift, bit 0 goes to C
                nextCtl.src = srcA;
                nextCtl.func = fnShift;
                nextCtl.updC = 1'b1;
            end
            opLdx: nextCtl.dest = regX;
            opLdy: nextCtl.dest = regY;
            opTax: begin
                nextCtl.src = srcA;
                nextCtl.dest = regX;
            end
            opTay: begin
                nextCtl.src = srcA;
                nextCtl.dest = regY;
            end
            opTxa: nextCtl.src = srcX;
            opTya: nextCtl.src = srcY;
            opFlg: begin
                // no register written, N and Z kept
                nextCtl.dest = regP;
                nextCtl.updNZ = 1'b0;
                nextCtl.flagCtl = cmd.arg.flags;
            end
            default: ;
        endcase
    end

    always_ff @(posedge rstAll) begin
        if (!rstN) begin
            ctlValid <= 1'b0;
        end else if (cmdReady) begin
            ctlValid <= cmdValid;
        end
    end

    // control word only loads on a transfer
    always_ff @(posedge rstAll) begin
        if (cmdValid && cmdReady) begin
            ctl <= nextCtl;
        end
    end

    legalOp: assert property (@(posedge rstAll) disable iff (!rstN)
        cmdValid && cmdReady |-> cmd.op inside {[opAdc:opFlg]});

    // a stalled item waits unchanged for commit
    ctlHeld: assert property (@(posedge rstAll) disable iff (!rstN)
        ctlValid && !ctlReady |=> ctlValid && $stable(ctl));

endmodule

// ==== design/aluExecute.sv ====
/*
 * execute stage and commit point
 * picks the operand, runs the binary ALU and the decimal adjust,
 * and forms the register write and flag updates
 */
`timescale 1ns/10ps

module aluExecute (
    input  logic                             ctlValid,
    input  alu6502Pkg::aluCtl_t              ctl,
    output logic                             ctlReady,
    input  logic [alu6502Pkg::dataWidth-1:0] regA,
    input  logic [alu6502Pkg::dataWidth-1:0] regX,
    input  logic [alu6502Pkg::dataWidth-1:0] regY,
    input  logic [alu6502Pkg::dataWidth-1:0] status,
    output logic                             commitValid,
    input  logic                             commitReady,
    output alu6502Pkg::regSel_e              dest,
    output logic [alu6502Pkg::dataWidth-1:0] value,
    output logic                             updC,
    output logic                             updV,
    output logic                             updNZ,
    output logic                             newC,
    output logic                             newV,
    output alu6502Pkg::flagCtl_t             flagCtl
);
    import alu6502Pkg::*;

    logic [dataWidth-1:0] srcVal;
    logic [dataWidth-1:0] addOperand;
    logic carryIn;
    logic [4:0] lowAdd;
    logic [4:0] highAdd;
    logic [dataWidth-1:0] binSum;
    logic [dataWidth-1:0] bcdSum;
    logic bcdCarry;
    logic decimalMode;

    // commit happens whenever the response slot can take it
    assign commitValid = ctlValid;
    assign ctlReady = commitReady;

    always_comb begin
        case (ctl.src)
            srcA: srcVal = regA;
            srcX: srcVal = regX;
            srcY: srcVal = regY;
            default: srcVal = ctl.operand;
        endcase
    end

    // SBC adds the one's complement with C as not-borrow
    assign addOperand = ctl.invert ? ~srcVal : srcVal;
    assign carryIn = ctl.useCarry && status[statusC];

    // two nibble adds give the half carry
    assign lowAdd = {1'b0, regA[3:0]} + {1'b0, addOperand[3:0]} + {4'd0, carryIn};
    assign highAdd = {1'b0, regA[7:4]} + {1'b0, addOperand[7:4]} + {4'd0, lowAdd[4]};
    assign binSum = {highAdd[3:0], lowAdd[3:0]};

    decimalAdjust i_decimalAdjust (
        .binSum   (binSum),
        .halfCarry(lowAdd[4]),
        .binCarry (highAdd[4]),
        .subtract (ctl.invert),
        .bcdSum   (bcdSum),
        .bcdCarry (bcdCarry)
    );

    assign decimalMode = status[statusD];

    always_comb begin
        newC = 1'b0;
        case (ctl.func)
            fnAdd: begin
                value = decimalMode ? bcdSum : binSum;
                newC = decimalMode ? bcdCarry : highAdd[4];
            end
            fnAnd: value = regA & srcVal;
            fnEor: value = regA ^ srcVal;
            fnOr: value = regA | srcVal;
            fnShift: begin
                value = {1'b0, srcVal[7:1]};
                newC = srcVal[0];
            end
            default: value = srcVal;
        endcase
    end

    // signed overflow of the binary add, also in decimal mode
    assign newV = (regA[7] == addOperand[7]) && (binSum[7] != regA[7]);

    assign dest = ctl.dest;
    assign updC = ctl.updC;
    assign updV = ctl.updV;
    assign updNZ = ctl.updNZ;
    assign flagCtl = ctl.flagCtl;

endmodule

// ==== design/statusFlags.sv ====
/*
 * processor status register
 * applies N, Z, C and V updates and the explicit
 * set and clear controls at each commit
 */
`timescale 1ns/10ps

module statusFlags (
    input  logic                             rstAll,
    input  logic                             rstN,
    input  logic                             commitFire,
    input  logic                             updC,
    input  logic                             updV,
    input  logic                             updNZ,
    input  logic                             newC,
    input  logic                             newV,
    input  logic [alu6502Pkg::dataWidth-1:0] value,
    input  alu6502Pkg::flagCtl_t             flagCtl,
    output logic [alu6502Pkg::dataWidth-1:0] status
);
    import alu6502Pkg::*;

    logic [dataWidth-1:0] nextStatus;

    always_comb begin
        nextStatus = status;
        if (updNZ) begin
            nextStatus[statusN] = value[7];
            nextStatus[statusZ] = value == '0;
        end
        if (updC) begin
            nextStatus[statusC] = newC;
        end
        if (updV) begin
            nextStatus[statusV] = newV;
        end
        // explicit controls, only nonzero on the flag op
        if (flagCtl.setC) nextStatus[statusC] = 1'b1;
        if (flagCtl.clrC) nextStatus[statusC] = 1'b0;
        if (flagCtl.setD) nextStatus[statusD] = 1'b1;
        if (flagCtl.clrD) nextStatus[statusD] = 1'b0;
        if (flagCtl.clrV) nextStatus[statusV] = 1'b0;
        // B and I not implemented
        nextStatus[4] = 1'b0;
        nextStatus[2] = 1'b0;
    end

    always_ff @(posedge rstAll) begin
        if (!rstN) begin
            status <= statusReset;
        end else if (commitFire) begin
            status <= nextStatus;
        end
    end

    // bit 5 comes from reset only, no update path may touch it
    bitOneHigh: assert property (@(posedge rstAll) disable iff (!rstN)
        status[statusOne]);

    noSetClrClash: assert property (@(posedge rstAll) disable iff (!rstN)
        commitFire |-> !(flagCtl.setC && flagCtl.clrC) && !(flagCtl.setD && flagCtl.clrD));

endmodule

// ==== design/resultCommit.sv ====
/*
 * architectural register file and response stage
 * writes A, X or Y at commit, holds the status register,
 * and presents one response per committed item
 */
`timescale 1ns/10ps

module resultCommit (
    input  logic                             rstAll,
    input  logic                             rstN,
    input  logic                             commitValid,
    output logic                             commitReady,
    input  alu6502Pkg::regSel_e              dest,
    input  logic [alu6502Pkg::dataWidth-1:0] value,
    input  logic                             updC,
    input  logic                             updV,
    input  logic                             updNZ,
    input  logic                             newC,
    input  logic                             newV,
    input  alu6502Pkg::flagCtl_t             flagCtl,
    output logic [alu6502Pkg::dataWidth-1:0] regA,
    output logic [alu6502Pkg::dataWidth-1:0] regX,
    output logic [alu6502Pkg::dataWidth-1:0] regY,
    output logic [alu6502Pkg::dataWidth-1:0] status,
    output logic                             rspValid,
    input  logic                             rspReady,
    output alu6502Pkg::aluRsp_t              rsp
);
    import alu6502Pkg::*;

    logic commitFire;
    regSel_e rspDest;
    logic [dataWidth-1:0] rspValue;

    // response slot empty or draining this edge
    assign commitReady = !rspValid || rspReady;
    assign commitFire = commitValid && commitReady;

    statusFlags i_statusFlags (
        .rstAll    (rstAll),
        .rstN      (rstN),
        .commitFire(commitFire),
        .updC      (updC),
        .updV      (updV),
        .updNZ     (updNZ),
        .newC      (newC),
        .newV      (newV),
        .value     (value),
        .flagCtl   (flagCtl),
        .status    (status)
    );

    always_ff @(posedge rstAll) begin
        if (!rstN) begin
            regA <= '0;
            regX <= '0;
            regY <= '0;
            rspValid <= 1'b0;
        end else begin
            if (commitFire) begin
                case (dest)
                    alu6502Pkg::regA: regA <= value;
                    alu6502Pkg::regX: regX <= value;
                    alu6502Pkg::regY: regY <= value;
                    default: ;
                endcase
            end
            if (commitFire) begin
                rspValid <= 1'b1;
            end else if (rspReady) begin
                rspValid <= 1'b0;
            end
        end
    end

    always_ff @(posedge rstAll) begin
        if (commitFire) begin
            rspDest <= dest;
            rspValue <= value;
        end
    end

    // status only moves together with a new response,
    // so the live register belongs to the held item
    assign rsp = '{dest: rspDest,
                   value: (rspDest == alu6502Pkg::regP) ? status : rspValue,
                   status: status};

    rspHeld: assert property (@(posedge rstAll) disable iff (!rstN)
        rspValid && !rspReady |=> rspValid && $stable(rsp));

endmodule

// ==== design/aluCore.sv ====
/*
 * 6502 datapath slice top level
 * decode stage, then execute and commit
 * command and response as valid/ready channels
 */
`timescale 1ns/10ps

module aluCore (
    input  logic                 rstAll,
    input  logic                 rstN,
    input  logic                 cmdValid,
    output logic                 cmdReady,
    input  alu6502Pkg::aluCmd_t  cmd,
    output logic                 rspValid,
    input  logic                 rspReady,
    output alu6502Pkg::aluRsp_t  rsp
);
    import alu6502Pkg::*;

    // decode to execute
    logic ctlValid;
    logic ctlReady;
    aluCtl_t ctl;

    // commit bundle
    logic commitValid;
    logic commitReady;
    regSel_e dest;
    logic [dataWidth-1:0] value;
    logic updC;
    logic updV;
    logic updNZ;
    logic newC;
    logic newV;
    flagCtl_t flagCtl;

    // architectural state fed back to execute
    logic [dataWidth-1:0] archA;
    logic [dataWidth-1:0] archX;
    logic [dataWidth-1:0] archY;
    logic [dataWidth-1:0] status;

    aluDecode i_aluDecode (
        .rstAll  (rstAll),
        .rstN    (rstN),
        .cmdValid(cmdValid),
        .cmdReady(cmdReady),
        .cmd     (cmd),
        .ctlValid(ctlValid),
        .ctl     (ctl),
        .ctlReady(ctlReady)
    );

    aluExecute i_aluExecute (
        .ctlValid   (ctlValid),
        .ctl        (ctl),
        .ctlReady   (ctlReady),
        .regA       (archA),
        .regX       (archX),
        .regY       (archY),
        .status     (status),
        .commitValid(commitValid),
        .commitReady(commitReady),
        .dest       (dest),
        .value      (value),
        .updC       (updC),
        .updV       (updV),
        .updNZ      (updNZ),
        .newC       (newC),
        .newV       (newV),
        .flagCtl    (flagCtl)
    );

    resultCommit i_resultCommit (
        .rstAll     (rstAll),
        .rstN       (rstN),
        .commitValid(commitValid),
        .commitReady(commitReady),
        .dest       (dest),
        .value      (value),
        .updC       (updC),
        .updV       (updV),
        .updNZ      (updNZ),
        .newC       (newC),
        .newV       (newV),
        .flagCtl    (flagCtl),
        .regA       (archA),
        .regX       (archX),
        .regY       (archY),
        .status     (status),
        .rspValid   (rspValid),
        .rspReady   (rspReady),
        .rsp        (rsp)
    );

endmodule

// ==== verif/aluModel.svh ====
/*
 * reference model for the 6502 datapath slice testbench
 * keeps its own A, X, Y and P, applies one command at a time,
 * and holds the LFSR that feeds the random stimulus
 */
`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

// random source state, seeded once
logic [15:0] lfsrState = 16'd44132;

// architectural state as the model sees it
logic [7:0] mdlA;
logic [7:0] mdlX;
logic [7:0] mdlY;
logic [7:0] mdlP;

// Fibonacci shift, taps 16 14 13 11
function automatic logic [15:0] lfsrNext(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

// one LFSR step per bit handed out
function automatic logic [31:0] takeBits(input int n);
    logic [31:0] bits;
    int i;
    bits = '0;
    for (i = 0; i < n; i++) begin
        bits = {bits[30:0], lfsrState[15]};
        lfsrState = lfsrNext(lfsrState);
    end
    return bits;
endfunction

task automatic clearModel();
    mdlA = '0;
    mdlX = '0;
    mdlY = '0;
    // only the always-one bit after reset
    mdlP = 8'b0010_0000;
endtask

// apply one command and return the response it should produce
function automatic aluRsp_t applyCommand(input aluCmd_t c);
    int a;
    int b;
    int cin;
    int sum;
    int lowSum;
    logic decHigh;
    logic [7:0] arg;
    logic [7:0] res;
    logic setsNZ;
    aluRsp_t r;
    arg = c.arg.operand;
    a = {24'd0, mdlA};
    b = {24'd0, arg};
    cin = {31'd0, mdlP[statusC]};
    res = arg;
    setsNZ = 1'b1;
    r.dest = regA;
    case (c.op)
        opAdc: begin
            sum = a + b + cin;
            lowSum = a % 16 + b % 16 + cin;
            res = sum[7:0];
            mdlP[statusC] = sum > 255;
            // overflow taken from the binary sum in both modes
            mdlP[statusV] = (mdlA[7] == arg[7]) && (res[7] != mdlA[7]);
            if (mdlP[statusD]) begin
                // high digit fix decided on the unadjusted sum
                decHigh = sum > 255 || sum % 256 > 153;
                if (sum % 16 > 9 || lowSum > 15) begin
                    res = res + bcdLowAdjust;
                end
                if (decHigh) begin
                    res = res + bcdHighAdjust;
                end
                mdlP[statusC] = decHigh;
            end
        end
        opSbc: begin
            // C clear means borrow in
            sum = a - b - (1 - cin);
            lowSum = a % 16 - b % 16 - (1 - cin);
            res = sum[7:0];
            mdlP[statusC] = sum >= 0;
            mdlP[statusV] = (mdlA[7] != arg[7]) && (res[7] != mdlA[7]);
            if (mdlP[statusD]) begin
                // a borrow out of a digit pulls that digit back by six
                if (lowSum < 0) begin
                    res = res - bcdLowAdjust;
                end
                if (sum < 0) begin
                    res = res - bcdHighAdjust;
                end
            end
        end
        opAnd: res = mdlA & arg;
        opEor: res = mdlA ^ arg;
        opOra: res = mdlA | arg;
        opLsr: begin
            mdlP[statusC] = mdlA[0];
            res = mdlA >> 1;
        end
        opLdx: r.dest = regX;
        opLdy: r.dest = regY;
        opTax: begin
            r.dest = regX;
            res = mdlA;
        end
        opTay: begin
            r.dest = regY;
            res = mdlA;
        end
        opTxa: res = mdlX;
        opTya: res = mdlY;
        opFlg: begin
            r.dest = regP;
            setsNZ = 1'b0;
            if (c.arg.flags.setC) mdlP[statusC] = 1'b1;
            if (c.arg.flags.clrC) mdlP[statusC] = 1'b0;
            if (c.arg.flags.setD) mdlP[statusD] = 1'b1;
            if (c.arg.flags.clrD) mdlP[statusD] = 1'b0;
            if (c.arg.flags.clrV) mdlP[statusV] = 1'b0;
        end
        default: ;
    endcase
    if (setsNZ) begin
        mdlP[statusN] = res[7];
        mdlP[statusZ] = (res == 8'h00);
    end
    case (r.dest)
        regA: mdlA = res;
        regX: mdlX = res;
        regY: mdlY = res;
        // flag op answers with the whole status byte
        default: res = mdlP;
    endcase
    r.value = res;
    r.status = mdlP;
    return r;
endfunction

`endif

// ==== verif/aluCoreTb.sv ====
/*
 * testbench for the 6502 datapath slice
 * LFSR driven command streams checked against a reference model,
 * with cmdValid gaps and rspReady back-pressure in the last test
 */
`timescale 1ns/10ps

module aluCoreTb;
    import alu6502Pkg::*;

    localparam int clkPeriod = 8;
    localparam int resetCycles = 16;
    localparam int lenBin = 300;
    localparam int lenBcd = 300;
    localparam int lenLogic = 300;
    localparam int lenMixed = 500;
    localparam int totalCmds = 1 + lenBin + lenBcd + lenLogic + lenMixed;

    logic rstAll = 1'b0;
    logic rstN;
    logic cmdValid;
    logic cmdReady;
    aluCmd_t cmd;
    logic rspValid;
    logic rspReady;
    aluRsp_t rsp;

    // expected responses in send order
    aluRsp_t expQ[$];
    aluRsp_t lastRsp;
    int checks;
    int errors;

    `include "aluModel.svh"

    aluCore i_aluCore (
        .rstAll  (rstAll),
        .rstN    (rstN),
        .cmdValid(cmdValid),
        .cmdReady(cmdReady),
        .cmd     (cmd),
        .rspValid(rspValid),
        .rspReady(rspReady),
        .rsp     (rsp)
    );

    always #(clkPeriod / 2) rstAll = ~rstAll;

    task automatic checkRsp(input aluRsp_t got, input aluRsp_t exp, input string what);
        checks++;
        if (got.dest !== exp.dest || got.value !== exp.value) begin
            errors++;
            $display("FAILED %0t ns: %s, dest %0d value %02h, expected dest %0d value %02h",
                     $time, what, got.dest, got.value, exp.dest, exp.value);
        end
    endtask

    task automatic checkStatus(input logic [7:0] got, input logic [7:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            // bits shown as NV1BDIZC
            $display("FAILED %0t ns: %s, status %08b, expected %08b", $time, what, got, exp);
        end
    endtask

    // dMode 1 keeps D set, 2 keeps it clear, else D is random
    function automatic flagCtl_t randomFlags(input int dMode);
        flagCtl_t f;
        logic [1:0] pick;
        f = '0;
        f.reserved = 3'(takeBits(3));
        // never set and clear the same flag
        pick = 2'(takeBits(2));
        f.setC = (pick == 2'd1);
        f.clrC = (pick == 2'd2);
        if (dMode == 1) begin
            f.setD = 1'b1;
        end else if (dMode == 2) begin
            f.clrD = 1'b1;
        end else begin
            pick = 2'(takeBits(2));
            f.setD = (pick == 2'd1);
            f.clrD = (pick == 2'd2);
        end
        f.clrV = 1'(takeBits(1));
        return f;
    endfunction

    function automatic logic [7:0] randomBcd();
        logic [3:0] hi;
        logic [3:0] lo;
        hi = 4'(takeBits(4) % 10);
        lo = 4'(takeBits(4) % 10);
        return {hi, lo};
    endfunction

    // command mix of each test
    function automatic aluCmd_t nextCmd(input int testId, input int idx);
        aluCmd_t c;
        int pick;
        c.op = opTxa;
        c.arg.operand = 8'(takeBits(8));
        case (testId)
            1: c.op = opTxa;
            2, 3: begin
                pick = int'(takeBits(2));
                if (testId == 3) begin
                    c.arg.operand = randomBcd();
                end
                if (idx == 0 || pick == 3) begin
                    // first item fixes the D mode for the whole test
                    c.op = opFlg;
                    c.arg.flags = randomFlags(testId == 3 ? 1 : 2);
                end else begin
                    c.op = (pick == 0) ? opAdc : (pick == 1) ? opSbc : opLda;
                end
            end
            4: begin
                if (idx == 0) begin
                    c.op = opFlg;
                    c.arg.flags = randomFlags(2);
                end else begin
                    // AND up to TYA
                    c.op = aluOp_e'(4'(2 + takeBits(4) % 11));
                end
            end
            default: begin
                c.op = aluOp_e'(4'(takeBits(4) % 14));
                if (c.op == opFlg) begin
                    c.arg.flags = randomFlags(0);
                end
            end
        endcase
        return c;
    endfunction

    // runs from falling edge to falling edge, random draws only there
    task automatic driveCommands(input int testId, input int count, input bit stress);
        aluCmd_t c;
        int gap;
        int i;
        for (i = 0; i < count; i++) begin
            c = nextCmd(testId, i);
            gap = stress ? int'(takeBits(2)) : 0;
            repeat (gap) @(negedge rstAll);
            cmd = c;
            cmdValid = 1'b1;
            @(posedge rstAll);
            while (!cmdReady) begin
                @(posedge rstAll);
            end
            // model moves at the transfer edge
            expQ.push_back(applyCommand(c));
            @(negedge rstAll);
            cmdValid = 1'b0;
        end
    endtask

    // rspReady is drawn on rising edges and driven on falling edges
    task automatic collectResponses(input int count, input bit stress);
        int got;
        logic readyNext;
        logic held;
        aluRsp_t heldRsp;
        aluRsp_t exp;
        got = 0;
        held = 1'b0;
        readyNext = 1'b1;
        while (got < count) begin
            rspReady = readyNext;
            @(posedge rstAll);
            if (held && !rspValid) begin
                errors++;
                $display("response dropped at %0t ns while it was held", $time);
            end
            if (held && rspValid) begin
                checkRsp(rsp, heldRsp, "held response changed");
                checkStatus(rsp.status, heldRsp.status, "held status changed");
            end
            held = rspValid && !rspReady;
            heldRsp = rsp;
            if (rspValid && rspReady) begin
                if (expQ.size() == 0) begin
                    errors++;
                    $display("response at %0t ns with no command outstanding", $time);
                end else begin
                    exp = expQ.pop_front();
                    checkRsp(rsp, exp, "response value");
                    checkStatus(rsp.status, exp.status, "response status");
                end
                lastRsp = rsp;
                got++;
            end
            readyNext = stress ? 1'(takeBits(1)) : 1'b1;
            @(negedge rstAll);
        end
    endtask

    // no response left over and none appears afterwards
    task automatic checkDrained(input int testId);
        logic extra;
        extra = 1'b0;
        rspReady = 1'b1;
        if (expQ.size() != 0) begin
            errors++;
            $display("test %0d ended with %0d responses missing", testId, expQ.size());
            expQ.delete();
        end
        repeat (4) begin
            @(posedge rstAll);
            extra = extra || rspValid;
        end
        if (extra) begin
            errors++;
            $display("test %0d got a response that no command asked for", testId);
        end
        @(negedge rstAll);
    endtask

    task automatic runTest(input int testId, input string name, input int count,
                           input bit stress);
        int errBefore;
        int chkBefore;
        aluRsp_t resetRsp;
        errBefore = errors;
        chkBefore = checks;
        fork
            driveCommands(testId, count, stress);
            collectResponses(count, stress);
        join
        checkDrained(testId);
        if (testId == 1) begin
            // A and X start at zero, so TXA only adds Z
            resetRsp = '{dest: regA, value: 8'h00, status: statusReset | (8'd1 << statusZ)};
            checkRsp(lastRsp, resetRsp, "TXA after reset");
            checkStatus(lastRsp.status, resetRsp.status, "status after reset");
        end
        $display("test %0d %s: %0d commands, %0d checks, %0d errors",
                 testId, name, count, checks - chkBefore, errors - errBefore);
    endtask

    initial begin
        rstN = 1'b0;
        cmdValid = 1'b0;
        cmd = '0;
        rspReady = 1'b1;
        checks = 0;
        errors = 0;
        clearModel();
        repeat (resetCycles) @(negedge rstAll);
        rstN = 1'b1;
        runTest(1, "TXA after reset", 1, 1'b0);
        runTest(2, "binary ADC and SBC", lenBin, 1'b0);
        runTest(3, "decimal ADC and SBC", lenBcd, 1'b0);
        runTest(4, "logic, loads and transfers", lenLogic, 1'b0);
        runTest(5, "random mix under back-pressure", lenMixed, 1'b1);
        $display("summary: %0d commands, %0d checks, %0d errors", totalCmds, checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // generous bound of 20 cycles per command
    initial begin
        #((totalCmds * 20 + resetCycles) * clkPeriod);
        $display("timeout after %0d cycles, a response never arrived",
                 totalCmds * 20 + resetCycles);
        $display("TEST FAIL");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+verif
design/alu6502Pkg.sv
design/decimalAdjust.sv
design/aluDecode.sv
design/aluExecute.sv
design/statusFlags.sv
design/resultCommit.sv
design/aluCore.sv
verif/aluCoreTb.sv

// ==== Makefile ====
# Verilator build and run for the 6502 datapath slice

VERILATOR ?= verilator
TOP ?= aluCoreTb
FILELIST ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert --timescale 1ns/10ps
LINT_FLAGS ?= -Wall
PASS_MSG ?= TEST PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# status comes from the search for the pass line
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --timescale 1ns/10ps $(LINT_FLAGS) \
		--top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
